/* run_sim.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module cpu_core_tb -f sim.f -o cpu_core_sim \
	&& ./obj_dir/cpu_core_sim | tee sim.log
grep -q "Finished with no errors" sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

/* sim.f */
verilog/cpu_pkg.sv
verilog/control_unit.sv
verilog/program_counter.sv
verilog/register_file.sv
verilog/alu.sv
verilog/data_memory.sv
verilog/cpu_core.sv
sim/cpu_core_assertions.sv
sim/cpu_core_tb.sv

/* sim/cpu_core_assertions.sv */
`timescale 1ns/1ps

module cpu_core_assertions #(
	parameter int PC_W = 16
) (
	input logic                     i_clk,
	input logic                     i_reset,
	input cpu_pkg::ctrl_t           i_ctrl,
	input logic [PC_W-1:0]          i_pc,
	input logic                     i_out_valid,
	input logic [cpu_pkg::XLEN-1:0] i_rt_data	// Register selected by the rt field
);
	import cpu_pkg::*;

	// Halt and input wait repeat the same instruction
	pc_holds_on_stall: assert property (@(posedge i_clk) disable iff (i_reset)
		i_ctrl.stall |=> i_pc == $past(i_pc))
		else $error("PC changed while the core was stalled");

	pc_steps_by_one: assert property (@(posedge i_clk) disable iff (i_reset)
		!i_ctrl.stall && i_ctrl.pc_source == PC_SEQ |=> i_pc == $past(i_pc) + PC_W'(1))
		else $error("PC did not advance to the next word");

	// A stalled instruction leaves its rt register untouched
	stall_keeps_rt: assert property (@(posedge i_clk) disable iff (i_reset)
		i_ctrl.stall |=> $stable(i_rt_data))
		else $error("Register written while the core was stalled");

	reset_clears_pc: assert property (@(posedge i_clk)
		i_reset |=> i_pc == '0 && !i_out_valid)
		else $error("Reset left the PC or the out strobe set");

endmodule

/* sim/cpu_core_tb.sv */
`timescale 1ns/1ps

module cpu_core_tb;
	import cpu_pkg::*;

	localparam int PC_W = 16;
	localparam alu_op_e R_OPS [18] = '{ALU_ADD, ALU_SUB, ALU_MUL, ALU_DIV, ALU_MOD, ALU_AND,
		ALU_OR, ALU_XOR, ALU_LAND, ALU_LOR, ALU_SLL, ALU_SRL, ALU_EQ, ALU_NE, ALU_LT, ALU_LE,
		ALU_GT, ALU_GE};
	localparam alu_op_e I_OPS [13] = '{ALU_ADD, ALU_SUB, ALU_MUL, ALU_DIV, ALU_MOD, ALU_AND,
		ALU_OR, ALU_XOR, ALU_NOT, ALU_LAND, ALU_LOR, ALU_SLL, ALU_SRL};

	logic            clk = 1'b0;
	logic            reset;
	logic            resume;
	logic            in_key;
	logic [31:0]     in_data;
	logic [31:0]     instr;
	logic [PC_W-1:0] pc;
	logic [31:0]     out_data;
	logic            out_valid;
	logic [31:0]     rom [256];		// Program ROM
	logic [31:0]     exp_q [$];		// Out values still to come
	logic [31:0]     exp_all [$];
	logic [31:0]     exp_word;
	logic [31:0]     lfsr = 32'h76b1_fc3f;
	logic [31:0]     in_word;
	int              n_instr = 0;
	int              n_checked = 0;
	int              errors = 0;
	int              halt_delay;
	int              in_delay;

	cpu_core #(.DATA_DEPTH(256), .PC_W(PC_W)) u_cpu_core (
		.i_clk (clk), .i_reset (reset), .i_instr (instr),
		.i_resume (resume), .i_in_key (in_key), .i_in_data (in_data),
		.o_pc (pc), .o_out_data (out_data), .o_out_valid (out_valid)
	);

	bind cpu_core cpu_core_assertions #(.PC_W(PC_W)) u_cpu_core_assertions (
		.i_clk (i_clk), .i_reset (i_reset), .i_ctrl (ctrl),
		.i_pc (o_pc), .i_out_valid (o_out_valid), .i_rt_data (rt_data)
	);

	always #5 clk = ~clk;

	assign instr = rom[pc[7:0]];	// Fetch answers in the same cycle

	// Galois LFSR stepped once for each bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[30:0], lfsr[0]};
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
		end
		return v;
	endfunction

	// Expected ALU result with signed compares and a zero divisor giving 0
	function automatic logic [31:0] model_alu(input alu_op_e op, input logic [31:0] a,
			input logic [31:0] b);
		case (op)
			ALU_ADD:  return a + b;
			ALU_SUB:  return a - b;
			ALU_MUL:  return a * b;
			ALU_DIV:  return (b == 0) ? 0 : $signed(a) / $signed(b);
			ALU_MOD:  return (b == 0) ? 0 : $signed(a) % $signed(b);
			ALU_SLL:  return a << b[4:0];
			ALU_SRL:  return a >> b[4:0];
			ALU_AND:  return a & b;
			ALU_OR:   return a | b;
			ALU_XOR:  return a ^ b;
			ALU_NOT:  return ~a;
			ALU_LAND: return {31'd0, (a != 0) && (b != 0)};
			ALU_LOR:  return {31'd0, (a != 0) || (b != 0)};
			ALU_EQ:   return {31'd0, a == b};
			ALU_NE:   return {31'd0, a != b};
			ALU_LT:   return {31'd0, $signed(a) < $signed(b)};
			ALU_LE:   return {31'd0, $signed(a) <= $signed(b)};
			ALU_GT:   return {31'd0, $signed(a) > $signed(b)};
			ALU_GE:   return {31'd0, $signed(a) >= $signed(b)};
			default:  return a;
		endcase
	endfunction

	task automatic emit_i(input opcode_e op, input int rs, input int rt, input int imm);
		rom[n_instr[7:0]] = {op, 5'(rs), 5'(rt), 16'(imm)};
		n_instr++;
	endtask

	task automatic emit_r(input func_e fn, input int rs, input int rt, input int rd);
		rom[n_instr[7:0]] = {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
		n_instr++;
	endtask

	task automatic emit_out(input int rs, input logic [31:0] value);
		emit_i(OP_OUT, rs, 0, 0);
		exp_q.push_back(value);
	endtask

	task automatic build_program();
		logic [31:0] a;
		logic [31:0] b;
		int          op;
		int          addr;
		int          sub;
		foreach (rom[i]) rom[i] = {OP_HALT, 26'(i)};
		emit_out(21, 32'd0);		// r21 is only written later, so reset must clear it
		emit_i(OP_LI, 0, 21, 16'h05a5);
		for (int f = 0; f < 18; f++) begin
			a = rand_bits(8);
			b = rand_bits(4) + 1;
			emit_i(OP_LI, 0, 1, a);
			emit_i(OP_LI, 0, 2, b);
			emit_r(func_e'(f), 1, 2, 3);
			emit_out(3, model_alu(R_OPS[f], a, b));
		end
		for (int k = 0; k < 15; k++) begin
			op = (k < 13) ? k + 1 : k - 9;	// Last two are divi and modi by zero
			a  = rand_bits(8);
			b  = (k < 13) ? rand_bits(4) + 1 : 32'd0;
			emit_i(OP_LI, 0, 1, a);
			emit_i(opcode_e'(op), 1, 3, b);
			emit_out(3, model_alu(I_OPS[op - 1], a, b));
		end
		a    = rand_bits(15);
		addr = rand_bits(8);
		emit_i(OP_LI, 0, 1, a);
		emit_i(OP_SW, 0, 1, addr);
		emit_i(OP_MOV, 1, 6, 0);
		emit_i(OP_LI, 0, 1, 0);
		emit_i(OP_LW, 0, 7, addr);
		emit_i(OP_LI, 0, 9, addr - 1);
		emit_i(OP_LA, 9, 8, 1);
		emit_out(6, a);
		emit_out(7, a);
		emit_out(8, a);
		emit_i(OP_LI, 0, 10, 16'h0111);
		emit_i(OP_LI, 0, 11, 16'h0222);
		emit_i(OP_J, 0, 0, n_instr + 2);
		emit_i(OP_OUT, 10, 0, 0);		// Skipped by j
		emit_i(OP_JF, 10, 0, n_instr + 2);	// r10 nonzero, not taken
		emit_out(11, 32'h0222);
		emit_i(OP_JF, 0, 0, n_instr + 2);	// r0 is zero, taken
		emit_i(OP_OUT, 10, 0, 0);
		sub = n_instr + 3;
		emit_i(OP_JAL, 0, 0, sub);
		emit_i(OP_OUT, 31, 0, 0);		// Link value after the return
		emit_i(OP_J, 0, 0, n_instr + 4);
		emit_i(OP_LI, 0, 12, 16'h0333);	// Subroutine
		emit_out(12, 32'h0333);
		emit_r(FN_JR, 31, 0, 0);
		exp_q.push_back(32'(sub - 2));
		emit_i(OP_HALT, 0, 0, 0);
		emit_out(21, 32'h05a5);
		in_word = rand_bits(32);
		emit_i(OP_IN, 0, 13, 0);
		emit_out(13, in_word);
		emit_i(OP_HALT, 0, 0, 0);		// End of program
		halt_delay = rand_bits(4) + 2;
		in_delay   = rand_bits(4) + 2;
	endtask

	// Hold a key low until the instruction waits on it, then press it for one cycle
	task automatic release_key(input opcode_e op, input int delay);
		do begin
			@(negedge clk);
		end while (instr[31:26] != op);
		repeat (delay) @(posedge clk);
		if (op == OP_HALT) resume <= 1'b1;
		else in_key <= 1'b1;
		@(posedge clk);
		resume <= 1'b0;
		in_key <= 1'b0;
	endtask

	always @(negedge clk) begin
		if (!reset && out_valid) begin
			assert (exp_q.size() > 0) else begin
				errors++;
				$display("Out pulse at %0t ns with no value left to expect", $time);
			end
			if (exp_q.size() > 0) begin
				exp_word = exp_q.pop_front();
				n_checked++;
				assert (out_data == exp_word) else begin
					errors++;
					$display("Fail %0t ns: out 0x%08h, expected 0x%08h", $time, out_data,
						exp_word);
				end
			end
		end
	end

	initial begin
		#1;
		repeat (2 * n_instr + halt_delay + in_delay + 120) @(posedge clk);
		$display("Timeout: the program did not produce all out values in time");
		$display("Finished with errors");
		$finish;
	end

	initial begin
		build_program();
		exp_all = exp_q;
		reset   = 1'b1;
		resume  = 1'b0;
		in_key  = 1'b0;
		in_data = in_word;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		while (n_checked < 10) @(posedge clk);
		reset <= 1'b1;		// Restart in the middle of the program
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		exp_q = exp_all;
		release_key(OP_HALT, halt_delay);
		release_key(OP_IN, in_delay);
		while (exp_q.size() != 0) @(posedge clk);
		repeat (5) @(negedge clk);
		$display("Checked %0d out values, %0d errors", n_checked, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

/* verilog/alu.sv */
`timescale 1ns/1ps

module alu (
	input  cpu_pkg::alu_op_e           i_op,
	input  logic [cpu_pkg::XLEN-1:0]   i_a,
	input  logic [cpu_pkg::XLEN-1:0]   i_b,
	output logic [cpu_pkg::XLEN-1:0]   o_result,
	output logic                       o_false	// A is zero, for jf
);
	import cpu_pkg::*;

	logic signed [XLEN-1:0] a_s;
	logic signed [XLEN-1:0] b_s;
	logic [4:0]             shamt;
	logic                   b_zero;

	assign a_s    = i_a;
	assign b_s    = i_b;
	assign shamt  = i_b[4:0];
	assign b_zero = (i_b == '0);

	always_comb begin
		case (i_op)
			ALU_ADD:    o_result = i_a + i_b;
			ALU_SUB:    o_result = i_a - i_b;
			ALU_MUL:    o_result = i_a * i_b;
			// Signed divide and remainder, zero divisor gives 0
			ALU_DIV:    o_result = b_zero ? '0 : a_s / b_s;
			ALU_MOD:    o_result = b_zero ? '0 : a_s % b_s;
			ALU_SLL:    o_result = i_a << shamt;
			ALU_SRL:    o_result = i_a >> shamt;	// Logical shift
			ALU_AND:    o_result = i_a & i_b;
			ALU_OR:     o_result = i_a | i_b;
			ALU_XOR:    o_result = i_a ^ i_b;
			ALU_NOT:    o_result = ~i_a;
			ALU_LAND:   o_result = XLEN'((i_a != '0) && !b_zero);
			ALU_LOR:    o_result = XLEN'((i_a != '0) || !b_zero);
			ALU_PASS_A: o_result = i_a;
			ALU_PASS_B: o_result = i_b;
			ALU_EQ:     o_result = XLEN'(a_s == b_s);
			ALU_NE:     o_result = XLEN'(a_s != b_s);
			ALU_LT:     o_result = XLEN'(a_s < b_s);
			ALU_LE:     o_result = XLEN'(a_s <= b_s);
			ALU_GT:     o_result = XLEN'(a_s > b_s);
			ALU_GE:     o_result = XLEN'(a_s >= b_s);
			default:    o_result = '0;
		endcase
	end

	assign o_false = (i_a == '0);

endmodule

/* verilog/control_unit.sv */
`timescale 1ns/1ps

module control_unit (
	input  cpu_pkg::opcode_e i_opcode,
	input  cpu_pkg::func_e   i_func,
	input  logic             i_false,	// rs is zero
	input  logic             i_resume,	// Key that releases halt
	input  logic             i_in_key,	// Key that accepts input
	output cpu_pkg::ctrl_t   o_ctrl
);
	import cpu_pkg::*;

	ctrl_t dec;

	always_comb begin
		dec           = '0;
		dec.pc_source = PC_SEQ;
		dec.alu_op    = ALU_ADD;

		case (i_opcode)
			OP_RTYPE: begin
				dec.reg_write  = 1'b1;
				dec.reg_alu_op = 1'b1;
				case (i_func)
					FN_ADD:  dec.alu_op = ALU_ADD;
					FN_SUB:  dec.alu_op = ALU_SUB;
					FN_MUL:  dec.alu_op = ALU_MUL;
					FN_DIV:  dec.alu_op = ALU_DIV;
					FN_MOD:  dec.alu_op = ALU_MOD;
					FN_AND:  dec.alu_op = ALU_AND;
					FN_OR:   dec.alu_op = ALU_OR;
					FN_XOR:  dec.alu_op = ALU_XOR;
					FN_LAND: dec.alu_op = ALU_LAND;
					FN_LOR:  dec.alu_op = ALU_LOR;
					FN_SLL:  dec.alu_op = ALU_SLL;
					FN_SRL:  dec.alu_op = ALU_SRL;
					FN_EQ:   dec.alu_op = ALU_EQ;
					FN_NE:   dec.alu_op = ALU_NE;
					FN_LT:   dec.alu_op = ALU_LT;
					FN_LET:  dec.alu_op = ALU_LE;
					FN_GT:   dec.alu_op = ALU_GT;
					FN_GET:  dec.alu_op = ALU_GE;
					FN_JR: begin
						dec.reg_write  = 1'b0;
						dec.reg_alu_op = 1'b0;
						dec.alu_op     = ALU_PASS_A;	// Target is rs
						dec.pc_source  = PC_JR;
					end
					default: begin
						dec.reg_write  = 1'b0;	// Unknown function is a no-op
						dec.reg_alu_op = 1'b0;
					end
				endcase
			end

			// Immediate arithmetic, logic and shifts write rt
			OP_ADDI, OP_SUBI, OP_MULI, OP_DIVI, OP_MODI,
			OP_ANDI, OP_ORI, OP_XORI, OP_NOT, OP_LANDI,
			OP_LORI, OP_SLLI, OP_SRLI: begin
				dec.reg_write = 1'b1;
				dec.rt_dest   = 1'b1;
				case (i_opcode)
					OP_SUBI:  dec.alu_op = ALU_SUB;
					OP_MULI:  dec.alu_op = ALU_MUL;
					OP_DIVI:  dec.alu_op = ALU_DIV;
					OP_MODI:  dec.alu_op = ALU_MOD;
					OP_ANDI:  dec.alu_op = ALU_AND;
					OP_ORI:   dec.alu_op = ALU_OR;
					OP_XORI:  dec.alu_op = ALU_XOR;
					OP_NOT:   dec.alu_op = ALU_NOT;
					OP_LANDI: dec.alu_op = ALU_LAND;
					OP_LORI:  dec.alu_op = ALU_LOR;
					OP_SLLI:  dec.alu_op = ALU_SLL;
					OP_SRLI:  dec.alu_op = ALU_SRL;
					default:  dec.alu_op = ALU_ADD;
				endcase
			end

			OP_MOV: begin
				dec.reg_write  = 1'b1;
				dec.rt_dest    = 1'b1;
				dec.reg_alu_op = 1'b1;
				dec.alu_op     = ALU_PASS_A;
			end
			OP_LW, OP_LA: begin
				dec.reg_write  = 1'b1;
				dec.rt_dest    = 1'b1;
				dec.mem_to_reg = 1'b1;	// Address is rs + imm
			end
			OP_LI: begin
				dec.reg_write = 1'b1;
				dec.rt_dest   = 1'b1;
				dec.alu_op    = ALU_PASS_B;
			end
			OP_SW:  dec.mem_write = 1'b1;
			OP_IN: begin
				dec.reg_write = 1'b1;
				dec.rt_dest   = 1'b1;
				dec.in_write  = 1'b1;
				dec.stall     = ~i_in_key;	// Wait for the input key
			end
			OP_OUT: begin
				dec.out_write = 1'b1;
				dec.alu_op    = ALU_PASS_A;
			end
			OP_JF: begin
				dec.alu_op    = ALU_PASS_A;
				dec.pc_source = i_false ? PC_JF : PC_SEQ;
			end
			OP_J:   dec.pc_source = PC_JUMP;
			OP_JAL: begin
				dec.reg_write = 1'b1;	// Link into r31
				dec.is_jal    = 1'b1;
				dec.pc_source = PC_JUMP;
			end
			OP_HALT: dec.stall = ~i_resume;
			default: ;
		endcase

		// A stalled instruction repeats with no side effects
		dec.reg_write = dec.reg_write & ~dec.stall;
		dec.mem_write = dec.mem_write & ~dec.stall;
	end

	assign o_ctrl = dec;

endmodule

/* verilog/cpu_core.sv */
`timescale 1ns/1ps

module cpu_core #(
	parameter int DATA_DEPTH = 256,
	parameter int PC_W       = 16
) (
	input  logic                     i_clk,
	input  logic                     i_reset,
	input  logic [cpu_pkg::XLEN-1:0] i_instr,		// From the program ROM at o_pc
	input  logic                     i_resume,
	input  logic                     i_in_key,
	input  logic [cpu_pkg::XLEN-1:0] i_in_data,
	output logic [PC_W-1:0]          o_pc,
	output logic [cpu_pkg::XLEN-1:0] o_out_data,
	output logic                     o_out_valid
);
	import cpu_pkg::*;

	localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd31;

	ctrl_t                 ctrl;
	logic [REG_ADDR_W-1:0] rs_addr;
	logic [REG_ADDR_W-1:0] rt_addr;
	logic [REG_ADDR_W-1:0] rd_addr;
	logic [REG_ADDR_W-1:0] wr_addr;
	logic [XLEN-1:0]       imm_ext;
	logic [XLEN-1:0]       rs_data;
	logic [XLEN-1:0]       rt_data;
	logic [XLEN-1:0]       alu_b;
	logic [XLEN-1:0]       alu_result;
	logic                  alu_false;
	logic [XLEN-1:0]       mem_rd_data;
	logic [XLEN-1:0]       wr_data;
	logic [PC_W-1:0]       pc_next_seq;

	// Instruction fields
	assign rs_addr = i_instr[25:21];
	assign rt_addr = i_instr[20:16];
	assign rd_addr = i_instr[15:11];
	assign imm_ext = {{(XLEN-IMM_W){i_instr[IMM_W-1]}}, i_instr[IMM_W-1:0]};

	control_unit u_control_unit (
		.i_opcode (opcode_e'(i_instr[XLEN-1 -: OPCODE_W])),
		.i_func   (func_e'(i_instr[FUNC_W-1:0])),
		.i_false  (alu_false),
		.i_resume (i_resume),
		.i_in_key (i_in_key),
		.o_ctrl   (ctrl)
	);

	program_counter #(.PC_W(PC_W)) u_program_counter (
		.i_clk         (i_clk),
		.i_reset       (i_reset),
		.i_pc_source   (ctrl.pc_source),
		.i_stall       (ctrl.stall),
		.i_target      (i_instr[TARGET_W-1:0]),
		.i_jr_addr     (alu_result[PC_W-1:0]),	// rs through PASS_A
		.o_pc          (o_pc),
		.o_pc_next_seq (pc_next_seq)
	);

	// Write-back destination and data
	assign wr_addr = ctrl.rt_dest ? rt_addr : (ctrl.is_jal ? LINK_REG : rd_addr);

	always_comb begin
		if (ctrl.mem_to_reg) begin
			wr_data = mem_rd_data;
		end else if (ctrl.in_write) begin
			wr_data = i_in_data;
		end else if (ctrl.is_jal) begin
			wr_data = {{(XLEN-PC_W){1'b0}}, pc_next_seq};
		end else begin
			wr_data = alu_result;
		end
	end

	register_file u_register_file (
		.i_clk     (i_clk),
		.i_reset   (i_reset),
		.i_rs_addr (rs_addr),
		.i_rt_addr (rt_addr),
		.i_wr_en   (ctrl.reg_write),
		.i_wr_addr (wr_addr),
		.i_wr_data (wr_data),
		.o_rs_data (rs_data),
		.o_rt_data (rt_data)
	);

	assign alu_b = ctrl.reg_alu_op ? rt_data : imm_ext;

	alu u_alu (
		.i_op     (ctrl.alu_op),
		.i_a      (rs_data),
		.i_b      (alu_b),
		.o_result (alu_result),
		.o_false  (alu_false)
	);

	data_memory #(.DATA_DEPTH(DATA_DEPTH)) u_data_memory (
		.i_clk     (i_clk),
		.i_reset   (i_reset),
		.i_wr_en   (ctrl.mem_write),
		.i_addr    (alu_result),
		.i_wr_data (rt_data),	// sw stores rt
		.o_rd_data (mem_rd_data)
	);

	// Output port, valid pulses for one cycle per out
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_out_data  <= '0;
			o_out_valid <= 1'b0;
		end else begin
			o_out_valid <= ctrl.out_write;
			if (ctrl.out_write) begin
				o_out_data <= alu_result;
			end
		end
	end

endmodule

/* verilog/cpu_pkg.sv */
package cpu_pkg;

	localparam int XLEN       = 32;		// Data width
	localparam int REG_ADDR_W = 5;		// Register index width
	localparam int OPCODE_W   = 6;
	localparam int FUNC_W     = 6;
	localparam int IMM_W      = 16;		// I-type immediate
	localparam int TARGET_W   = 26;		// J-type target

	// Instruction opcodes, R-type is 0 and uses the function field
	typedef enum logic [OPCODE_W-1:0] {
		OP_RTYPE = 6'd0,
		OP_ADDI  = 6'd1,  OP_SUBI  = 6'd2,  OP_MULI  = 6'd3,
		OP_DIVI  = 6'd4,  OP_MODI  = 6'd5,  OP_ANDI  = 6'd6,
		OP_ORI   = 6'd7,  OP_XORI  = 6'd8,  OP_NOT   = 6'd9,
		OP_LANDI = 6'd10, OP_LORI  = 6'd11, OP_SLLI  = 6'd12,
		OP_SRLI  = 6'd13, OP_MOV   = 6'd14, OP_LW    = 6'd15,
		OP_LI    = 6'd16, OP_LA    = 6'd17, OP_SW    = 6'd18,
		OP_IN    = 6'd19, OP_OUT   = 6'd20, OP_JF    = 6'd21,
		OP_J     = 6'd22, OP_JAL   = 6'd23, OP_HALT  = 6'd24
	} opcode_e;

	// R-type function codes
	typedef enum logic [FUNC_W-1:0] {
		FN_ADD  = 6'd0,  FN_SUB  = 6'd1,  FN_MUL  = 6'd2,
		FN_DIV  = 6'd3,  FN_MOD  = 6'd4,  FN_AND  = 6'd5,
		FN_OR   = 6'd6,  FN_XOR  = 6'd7,  FN_LAND = 6'd8,
		FN_LOR  = 6'd9,  FN_SLL  = 6'd10, FN_SRL  = 6'd11,
		FN_EQ   = 6'd12, FN_NE   = 6'd13, FN_LT   = 6'd14,
		FN_LET  = 6'd15, FN_GT   = 6'd16, FN_GET  = 6'd17,
		FN_JR   = 6'd18
	} func_e;

	typedef enum logic [4:0] {
		ALU_ADD  = 5'd0,  ALU_SUB  = 5'd1,  ALU_MUL    = 5'd2,
		ALU_DIV  = 5'd3,  ALU_MOD  = 5'd4,
		ALU_SLL  = 5'd5,  ALU_SRL  = 5'd6,
		ALU_AND  = 5'd8,  ALU_OR   = 5'd9,  ALU_XOR    = 5'd10,
		ALU_NOT  = 5'd11,
		ALU_LAND = 5'd12, ALU_LOR  = 5'd13,
		ALU_PASS_A = 5'd14, ALU_PASS_B = 5'd15,
		ALU_EQ   = 5'd16, ALU_NE   = 5'd17, ALU_LT     = 5'd18,
		ALU_LE   = 5'd19, ALU_GT   = 5'd20, ALU_GE     = 5'd21
	} alu_op_e;

	// Next PC source
	typedef enum logic [1:0] {
		PC_SEQ  = 2'd0,		// PC+1
		PC_JF   = 2'd1,		// Jump if false, taken
		PC_JR   = 2'd2,		// Jump register
		PC_JUMP = 2'd3		// Jump target
	} pc_src_e;

	typedef struct packed {
		logic    reg_write;
		logic    mem_write;
		logic    mem_to_reg;
		logic    reg_alu_op;	// B operand from rt, else immediate
		logic    rt_dest;		// Write to rt, else rd
		logic    is_jal;
		logic    in_write;
		logic    out_write;
		logic    stall;		// Hold PC, halt or input wait
		pc_src_e pc_source;
		alu_op_e alu_op;
	} ctrl_t;

endpackage

/* verilog/data_memory.sv */
`timescale 1ns/1ps

module data_memory #(
	parameter int DATA_DEPTH = 256
) (
	input  logic                     i_clk,
	input  logic                     i_reset,
	input  logic                     i_wr_en,
	input  logic [cpu_pkg::XLEN-1:0] i_addr,	// Word address
	input  logic [cpu_pkg::XLEN-1:0] i_wr_data,
	output logic [cpu_pkg::XLEN-1:0] o_rd_data
);
	import cpu_pkg::*;

	localparam int ADDR_W = $clog2(DATA_DEPTH);

	logic [XLEN-1:0]   mem [DATA_DEPTH];
	logic [ADDR_W-1:0] index;

	assign index = i_addr[ADDR_W-1:0];	// Upper address bits wrap

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			for (int i = 0; i < DATA_DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (i_wr_en) begin
			mem[index] <= i_wr_data;
		end
	end

	assign o_rd_data = mem[index];

endmodule

/* verilog/program_counter.sv */
`timescale 1ns/1ps

module program_counter #(
	parameter int PC_W = 16
) (
	input  logic                       i_clk,
	input  logic                       i_reset,
	input  cpu_pkg::pc_src_e           i_pc_source,
	input  logic                       i_stall,
	input  logic [cpu_pkg::TARGET_W-1:0] i_target,	// Jump target or jf immediate
	input  logic [PC_W-1:0]            i_jr_addr,
	output logic [PC_W-1:0]            o_pc,
	output logic [PC_W-1:0]            o_pc_next_seq	// Also the jal link value
);
	import cpu_pkg::*;

	logic [PC_W-1:0] pc;
	logic [PC_W-1:0] pc_next;

	assign o_pc_next_seq = pc + 1'b1;

	always_comb begin
		case (i_pc_source)
			PC_JF, PC_JUMP: pc_next = i_target[PC_W-1:0];
			PC_JR:          pc_next = i_jr_addr;
			default:        pc_next = o_pc_next_seq;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			pc <= '0;
		end else if (!i_stall) begin
			pc <= pc_next;
		end
	end

	assign o_pc = pc;

endmodule

/* verilog/register_file.sv */
`timescale 1ns/1ps

module register_file (
	input  logic                           i_clk,
	input  logic                           i_reset,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] i_rs_addr,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] i_rt_addr,
	input  logic                           i_wr_en,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] i_wr_addr,
	input  logic [cpu_pkg::XLEN-1:0]       i_wr_data,
	output logic [cpu_pkg::XLEN-1:0]       o_rs_data,
	output logic [cpu_pkg::XLEN-1:0]       o_rt_data
);
	import cpu_pkg::*;

	localparam int NUM_REGS = 1 << REG_ADDR_W;

	logic [XLEN-1:0] regs [NUM_REGS];

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wr_en && i_wr_addr != '0) begin	// r0 stays zero
			regs[i_wr_addr] <= i_wr_data;
		end
	end

	assign o_rs_data = (i_rs_addr == '0) ? '0 : regs[i_rs_addr];
	assign o_rt_data = (i_rt_addr == '0) ? '0 : regs[i_rt_addr];

endmodule
